//--- build.f
+incdir+.
fft_pkg.sv
fft_butterfly.sv
fft_stage_engine.sv
fft_frame_buffer.sv
fft_control.sv
fft_output_stage.sv
fft_top.sv
fft_asserts.sv
tb_fft.sv

//--- fft_asserts.sv
`timescale 1ns/1ps

module fft_asserts
	import fft_pkg::*;
(
	input logic   clk,
	input logic   reset,
	input logic   start,
	input logic   load,
	input logic   capture,
	input logic   done,
	input frame_t freq_out
);

	// A shown result needs start held over the previous edge
	done_after_start: assert property (@(posedge clk) disable iff (!reset)
		done |-> $past(start))
		else $error("done high without start high one cycle earlier");

	no_result_zero: assert property (@(posedge clk) disable iff (!reset)
		!done |-> (freq_out == '0))
		else $error("freq_out not zero while done is low");

	// Load is seen at the load edge, done one sample after the fourth pass
	done_latency: assert property (@(posedge clk) disable iff (!reset)
		$rose(done) |-> $past(load, 5))
		else $error("done did not rise four cycles after the load edge");

	capture_single: assert property (@(posedge clk) disable iff (!reset)
		capture |=> !capture)
		else $error("capture high for more than one cycle");

endmodule

bind fft_top fft_asserts u_asserts (
	.clk      (clk),
	.reset    (reset),
	.start    (start),
	.load     (load),
	.capture  (capture),
	.done     (done),
	.freq_out (freq_out)
);

//--- fft_butterfly.sv
`timescale 1ns/1ps
`include "fft_cfg.svh"

module fft_butterfly
	import fft_pkg::*;
(
	input  cplx_t a,
	input  cplx_t b,
	input  cplx_t w,
	output cplx_t p,
	output cplx_t n
);

	localparam int SW = `FFT_SAMPLE_W;
	// Sum of two full products needs one bit more than a single product
	localparam int PROD_W = 2 * SW + 1;

	logic signed [SW-1:0] a_re;
	logic signed [SW-1:0] a_im;
	logic signed [SW-1:0] b_re;
	logic signed [SW-1:0] b_im;
	logic signed [SW-1:0] w_re;
	logic signed [SW-1:0] w_im;
	logic signed [PROD_W-1:0] prod_re;
	logic signed [PROD_W-1:0] prod_im;
	logic signed [SW-1:0] t_re;
	logic signed [SW-1:0] t_im;

	assign a_re = a.re;
	assign a_im = a.im;
	assign b_re = b.re;
	assign b_im = b.im;
	assign w_re = w.re;
	assign w_im = w.im;

	// Complex multiply t = b * w
	always_comb begin
		prod_re = b_re * w_re - b_im * w_im;
		prod_im = b_re * w_im + b_im * w_re;
		// Drop the twiddle fraction, rounding toward minus infinity
		t_re = SW'(prod_re >>> `FFT_FRAC);
		t_im = SW'(prod_im >>> `FFT_FRAC);
	end

	// Sum and difference, both wrap at the sample width
	always_comb begin
		p.re = a_re + t_re;
		p.im = a_im + t_im;
		n.re = a_re - t_re;
		n.im = a_im - t_im;
	end

endmodule

//--- fft_cfg.svh
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// Frame size and number of radix-2 passes
`define FFT_POINTS 16
`define FFT_STAGES 4

// Butterflies working in parallel, half the point count
`define FFT_BFLIES 8

// Bits per real or imaginary part
`define FFT_SAMPLE_W 18

// Twiddles are Q1.17
`define FFT_FRAC 17

// Index widths derived from the sizes above
`define FFT_STAGE_W 2
`define FFT_IDX_W 4

`endif

//--- fft_control.sv
`timescale 1ns/1ps
`include "fft_cfg.svh"

module fft_control
	import fft_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	output logic   load,
	output logic   advance,
	output logic   capture,
	output logic   done,
	output stage_t stage
);

	localparam stage_t LAST_STAGE = stage_t'(`FFT_STAGES - 1);

	ctrl_state_t state;
	ctrl_state_t state_next;
	stage_t stage_next;

	// Next state and stage counter
	always_comb begin
		state_next = state;
		stage_next = stage;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = RUN;
					stage_next = '0;
				end
			end
			RUN: begin
				// Counter wraps back to zero after the last pass
				stage_next = stage + stage_t'(1);
				if (stage == LAST_STAGE) begin
					state_next = DONE;
				end
			end
			DONE: begin
				// Result is held until start is released
				if (!start) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
				stage_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
			stage <= '0;
		end else begin
			state <= state_next;
			stage <= stage_next;
		end
	end

	assign load = (state == IDLE) && start;
	assign advance = (state == RUN);
	// Final pass result is taken at the same edge it is written
	assign capture = (state == RUN) && (stage == LAST_STAGE);
	assign done = (state == DONE);

endmodule

//--- fft_frame_buffer.sv
`timescale 1ns/1ps
`include "fft_cfg.svh"

module fft_frame_buffer
	import fft_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   load,
	input  logic   advance,
	input  frame_t time_in,
	input  frame_t next_frame,
	output frame_t work_frame
);

	localparam int PTS = `FFT_POINTS;
	localparam int IW = `FFT_IDX_W;

	frame_t loaded;

	function automatic logic [IW-1:0] bit_rev(input logic [IW-1:0] v);
		logic [IW-1:0] r;
		for (int b = 0; b < IW; b++) begin
			r[b] = v[IW-1-b];
		end
		return r;
	endfunction

	// Input frame in bit-reversed order for the DIT passes
	always_comb begin
		for (int i = 0; i < PTS; i++) begin
			loaded[i] = time_in[bit_rev(IW'(i))];
		end
	end

	// Load has priority, then one pass per advance cycle
	always_ff @(posedge clk) begin
		if (!reset) begin
			work_frame <= '0;
		end else if (load) begin
			work_frame <= loaded;
		end else if (advance) begin
			work_frame <= next_frame;
		end
	end

endmodule

//--- fft_output_stage.sv
`timescale 1ns/1ps

module fft_output_stage
	import fft_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   capture,
	input  logic   done,
	input  frame_t next_frame,
	output frame_t freq_out
);

	frame_t result;

	// Keeps the last pass of the frame
	always_ff @(posedge clk) begin
		if (!reset) begin
			result <= '0;
		end else if (capture) begin
			result <= next_frame;
		end
	end

	// Output reads zero whenever no result is on show
	assign freq_out = done ? result : '0;

endmodule

//--- fft_pkg.sv
`include "fft_cfg.svh"

package fft_pkg;

	// One complex sample, real part in the upper half
	typedef struct packed {
		logic signed [`FFT_SAMPLE_W-1:0] re;
		logic signed [`FFT_SAMPLE_W-1:0] im;
	} cplx_t;

	// Whole frame, entry 0 in the lowest bits
	typedef cplx_t [`FFT_POINTS-1:0] frame_t;

	// Index of the pass being computed
	typedef logic [`FFT_STAGE_W-1:0] stage_t;

	// Controller states
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} ctrl_state_t;

endpackage

//--- fft_stage_engine.sv
`timescale 1ns/1ps
`include "fft_cfg.svh"

module fft_stage_engine
	import fft_pkg::*;
(
	input  stage_t stage,
	input  frame_t work_frame,
	output frame_t next_frame
);

	localparam int SW = `FFT_SAMPLE_W;
	localparam int IW = `FFT_IDX_W;
	localparam int BF = `FFT_BFLIES;
	localparam int TIW = $clog2(`FFT_BFLIES);
	localparam int LAST = `FFT_STAGES - 1;
	// Largest positive Q1.17 value stands in for 1.0
	localparam int ONE = (1 << `FFT_FRAC) - 1;

	// W^m = cos(2*pi*m/16) + j*sin(2*pi*m/16) scaled by ONE for m = 0..7
	localparam cplx_t TWIDDLE [BF] = '{
		'{re: SW'(ONE),     im: SW'(0)},
		'{re: SW'(121094),  im: SW'(50159)},
		'{re: SW'(92681),   im: SW'(92681)},
		'{re: SW'(50159),   im: SW'(121094)},
		'{re: SW'(0),       im: SW'(ONE)},
		'{re: SW'(-50159),  im: SW'(121094)},
		'{re: SW'(-92681),  im: SW'(92681)},
		'{re: SW'(-121094), im: SW'(50159)}
	};

	logic [IW-1:0] top_idx [BF];
	logic [IW-1:0] bot_idx [BF];
	logic [TIW-1:0] tw_idx [BF];
	cplx_t bfly_a [BF];
	cplx_t bfly_b [BF];
	cplx_t bfly_w [BF];
	cplx_t bfly_p [BF];
	cplx_t bfly_n [BF];

	genvar j;
	generate
		for (j = 0; j < BF; j++) begin : g_bfly
			// In-place DIT routing for butterfly j in the current pass
			always_comb begin
				int shift;
				int span;
				int grp;
				int off;
				shift = int'(stage);
				span = 1 << shift;
				grp = j >> shift;
				off = j & (span - 1);
				top_idx[j] = IW'((grp << (shift + 1)) + off);
				bot_idx[j] = IW'((grp << (shift + 1)) + off + span);
				// Twiddle step halves with every pass
				tw_idx[j] = TIW'(off << (LAST - shift));
			end

			assign bfly_a[j] = work_frame[top_idx[j]];
			assign bfly_b[j] = work_frame[bot_idx[j]];
			assign bfly_w[j] = TWIDDLE[tw_idx[j]];

			fft_butterfly u_bfly (
				.a (bfly_a[j]),
				.b (bfly_b[j]),
				.w (bfly_w[j]),
				.p (bfly_p[j]),
				.n (bfly_n[j])
			);
		end
	endgenerate

	// Results go back to the slots they were read from
	always_comb begin
		next_frame = work_frame;
		for (int k = 0; k < BF; k++) begin
			next_frame[top_idx[k]] = bfly_p[k];
			next_frame[bot_idx[k]] = bfly_n[k];
		end
	end

endmodule

//--- fft_top.sv
`timescale 1ns/1ps

module fft_top
	import fft_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  frame_t time_in,
	output frame_t freq_out,
	output logic   done
);

	logic load;
	logic advance;
	logic capture;
	stage_t stage;
	frame_t work_frame;
	frame_t next_frame;

	fft_control u_control (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.load    (load),
		.advance (advance),
		.capture (capture),
		.done    (done),
		.stage   (stage)
	);

	// Working frame, one pass per cycle
	fft_frame_buffer u_buffer (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.advance    (advance),
		.time_in    (time_in),
		.next_frame (next_frame),
		.work_frame (work_frame)
	);

	fft_stage_engine u_engine (
		.stage      (stage),
		.work_frame (work_frame),
		.next_frame (next_frame)
	);

	fft_output_stage u_output (
		.clk        (clk),
		.reset      (reset),
		.capture    (capture),
		.done       (done),
		.next_frame (next_frame),
		.freq_out   (freq_out)
	);

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module tb_fft -o tb_fft_sim || exit 1
./obj_dir/tb_fft_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

//--- tb_fft.sv
`timescale 1ns/1ps
`include "fft_cfg.svh"

module tb_fft
	import fft_pkg::*;
();

	localparam int FRAMES = 200;
	localparam int PTS = `FFT_POINTS;
	localparam int STAGES = `FFT_STAGES;
	localparam int BFLIES = `FFT_BFLIES;
	localparam int SW = `FFT_SAMPLE_W;
	localparam int FRAC = `FFT_FRAC;
	localparam int IDX_W = `FFT_IDX_W;
	localparam int MAX_Q = (1 << FRAC) - 1;
	localparam int DRIVE_DELAY = 5;
	localparam int CYCLES_PER_FRAME = 16;
	// Frame budget plus reset and slack in ns at a 100 ns period
	localparam int WATCHDOG_NS = (FRAMES * CYCLES_PER_FRAME + 40) * 100;
	localparam real PI = 3.14159265358979323846;

	logic clk;
	logic reset;
	logic start;
	frame_t time_in;
	frame_t freq_out;
	logic done;

	logic [31:0] rng_state;
	int tw_re [BFLIES];
	int tw_im [BFLIES];

	fft_top dut (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.time_in  (time_in),
		.freq_out (freq_out),
		.done     (done)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Uniform value in -4095..4095
	function int rand_sample();
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16] % 16'd8191) - 4095;
	endfunction

	function frame_t random_frame();
		frame_t f;
		for (int i = 0; i < PTS; i++) begin
			f[i].re = SW'(rand_sample());
			f[i].im = SW'(rand_sample());
		end
		return f;
	endfunction

	// Q1.17 code with full scale mapped to the largest positive value
	function automatic int round_q17(input real x);
		real scaled;
		int v;
		scaled = x * real'(MAX_Q);
		if (scaled >= 0.0) begin
			v = $rtoi(scaled + 0.5);
		end else begin
			v = -$rtoi(0.5 - scaled);
		end
		return v;
	endfunction

	task automatic init_twiddles();
		real angle;
		for (int m = 0; m < BFLIES; m++) begin
			angle = 2.0 * PI * real'(m) / real'(PTS);
			tw_re[m] = round_q17($cos(angle));
			tw_im[m] = round_q17($sin(angle));
		end
	endtask

	function automatic int bit_reverse(input int v);
		int r;
		r = 0;
		for (int b = 0; b < IDX_W; b++) begin
			if ((v & (1 << b)) != 0) begin
				r = r | (1 << (IDX_W - 1 - b));
			end
		end
		return r;
	endfunction

	// t = b * W^m scaled back by the twiddle fraction with floor rounding
	function automatic cplx_t twiddle_mul(input cplx_t b, input int m);
		longint prod_re;
		longint prod_im;
		cplx_t t;
		prod_re = longint'(b.re) * longint'(tw_re[m]) - longint'(b.im) * longint'(tw_im[m]);
		prod_im = longint'(b.re) * longint'(tw_im[m]) + longint'(b.im) * longint'(tw_re[m]);
		t.re = SW'(prod_re >>> FRAC);
		t.im = SW'(prod_im >>> FRAC);
		return t;
	endfunction

	function automatic cplx_t cplx_add(input cplx_t a, input cplx_t b);
		cplx_t r;
		r.re = a.re + b.re;
		r.im = a.im + b.im;
		return r;
	endfunction

	function automatic cplx_t cplx_sub(input cplx_t a, input cplx_t b);
		cplx_t r;
		r.re = a.re - b.re;
		r.im = a.im - b.im;
		return r;
	endfunction

	// Reference DIT FFT with bit-reversed load and in-place passes
	function automatic frame_t fft_model(input frame_t x);
		frame_t f;
		cplx_t a;
		cplx_t t;
		int h;
		int g;
		int k;
		int top;
		int bot;
		for (int i = 0; i < PTS; i++) begin
			f[i] = x[bit_reverse(i)];
		end
		for (int s = 0; s < STAGES; s++) begin
			h = 1 << s;
			for (int j = 0; j < BFLIES; j++) begin
				g = j / h;
				k = j % h;
				top = g * 2 * h + k;
				bot = top + h;
				a = f[top];
				t = twiddle_mul(f[bot], k * (BFLIES / h));
				f[top] = cplx_add(a, t);
				f[bot] = cplx_sub(a, t);
			end
		end
		return f;
	endfunction

	task automatic compare_frame(input frame_t expected, input frame_t actual);
		for (int k = 0; k < PTS; k++) begin
			if (actual[k] !== expected[k]) begin
				$display("mismatch freq_out[%0d]: expected %h, actual %h",
					k, expected[k], actual[k]);
				abort_run("freq_out differs from the model");
			end
		end
	endtask

	task automatic compare_done(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch done: expected %h, actual %h", expected, actual);
			abort_run("done differs from the expected level");
		end
	endtask

	task automatic expect_no_result();
		compare_done(1'b0, done);
		compare_frame('0, freq_out);
	endtask

	task automatic run_frame(input frame_t x, input int hold);
		frame_t expected;
		expected = fft_model(x);
		start = 1'b1;
		time_in = x;
		// Load edge and the first three passes show nothing
		for (int c = 0; c < STAGES; c++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			expect_no_result();
			time_in = random_frame();
		end
		@(posedge clk);
		#DRIVE_DELAY;
		compare_done(1'b1, done);
		compare_frame(expected, freq_out);
		// Result must hold while start stays high
		for (int h = 0; h < hold; h++) begin
			time_in = random_frame();
			@(posedge clk);
			#DRIVE_DELAY;
			compare_done(1'b1, done);
			compare_frame(expected, freq_out);
		end
		start = 1'b0;
		@(posedge clk);
		#DRIVE_DELAY;
		expect_no_result();
	endtask

	// Starts a frame and pulls reset low before it completes
	task automatic reset_mid_run(input frame_t x, input int cut);
		start = 1'b1;
		time_in = x;
		@(posedge clk);
		#DRIVE_DELAY;
		for (int c = 0; c < cut; c++) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		reset = 1'b0;
		start = 1'b0;
		repeat (4) begin
			@(posedge clk);
			#DRIVE_DELAY;
			expect_no_result();
		end
		reset = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		expect_no_result();
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout: the test sequence did not finish in the expected time");
	end

	initial begin
		rng_state = 32'h46aafe17;
		reset = 1'b0;
		start = 1'b0;
		time_in = '0;
		init_twiddles();

		repeat (10) begin
			@(posedge clk);
			#DRIVE_DELAY;
			expect_no_result();
		end
		reset = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		expect_no_result();

		for (int f = 0; f < FRAMES; f++) begin
			if (f % 25 == 12) begin
				reset_mid_run(random_frame(), int'(next_rand() >> 30));
			end
			run_frame(random_frame(), int'(next_rand() >> 29));
		end

		$display("TEST PASS");
		$finish;
	end

endmodule
